//--- source/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // exception code field width
    localparam int ECODE_W = 6;

    // load kind carried from decode
    typedef enum logic [2:0] {
        ld_none = 3'd0,
        ld_b    = 3'd1,
        ld_bu   = 3'd2,
        ld_h    = 3'd3,
        ld_hu   = 3'd4,
        ld_w    = 3'd5
    } ld_op_e;

    // where the writeback value comes from
    typedef enum logic [2:0] {
        src_alu    = 3'd0,
        src_mem    = 3'd1,
        src_mul_lo = 3'd2,
        src_mul_hi = 3'd3,
        src_div    = 3'd4
    } res_src_e;

endpackage

`default_nettype wire

//--- source/mem_pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module mem_pipe_reg (
    input  wire                         clk,
    input  wire                         resetn,
    input  wire                         ex_valid,
    input  wire                         ex_rf_we,
    input  wire  [4:0]                  ex_rf_waddr,
    input  wire  [31:0]                 ex_pc,
    input  wire  [31:0]                 ex_alu_result,
    input  wire  [31:0]                 ex_div_result,
    input  wire  mem_pkg::ld_op_e       ex_ld_op,
    input  wire  mem_pkg::res_src_e     ex_res_src,
    input  wire                         ex_has_ex,
    input  wire                         ex_ertn,
    input  wire  [mem_pkg::ECODE_W-1:0] ex_ecode,
    input  wire                         wb_allowin,
    input  wire                         mem_flush,
    output wire                         mem_allowin,
    output logic                        mem_valid,
    output logic                        ms_rf_we,
    output logic [4:0]                  ms_rf_waddr,
    output logic [31:0]                 ms_pc,
    output logic [31:0]                 ms_alu_result,
    output logic [31:0]                 ms_div_result,
    output mem_pkg::ld_op_e             ms_ld_op,
    output mem_pkg::res_src_e           ms_res_src,
    output logic                        ms_has_ex,
    output logic                        ms_ertn,
    output logic [mem_pkg::ECODE_W-1:0] ms_ecode
);

    logic accept;

    // one-cycle stage, so no ready-go term
    assign mem_allowin = ~mem_valid | wb_allowin | mem_flush;
    assign accept      = ex_valid & mem_allowin;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_valid <= 1'b0;
        end else if (mem_allowin) begin
            mem_valid <= ex_valid; // flush drops the held item here
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ms_rf_we      <= ex_rf_we;
            ms_rf_waddr   <= ex_rf_waddr;
            ms_pc         <= ex_pc;
            ms_alu_result <= ex_alu_result;
            ms_div_result <= ex_div_result;
            ms_ld_op      <= ex_ld_op;
            ms_res_src    <= ex_res_src;
            ms_has_ex     <= ex_has_ex;
            ms_ertn       <= ex_ertn;
            ms_ecode      <= ex_ecode;
        end
    end

endmodule

`default_nettype wire

//--- source/load_extract.sv
`timescale 1ns/1ps
`default_nettype none

module load_extract (
    input  wire  [31:0]           data_sram_rdata,
    input  wire  [1:0]            byte_offset,
    input  wire  mem_pkg::ld_op_e ld_op,
    output logic [31:0]           load_data
);

    import mem_pkg::*;

    logic [31:0] shifted;

    // bring the addressed byte or half down to lane 0
    assign shifted = data_sram_rdata >> {byte_offset, 3'b000};

    always_comb begin
        case (ld_op)
            ld_b: begin
                load_data = {{24{shifted[7]}}, shifted[7:0]};
            end
            ld_bu: begin
                load_data = {24'b0, shifted[7:0]};
            end
            ld_h: begin
                load_data = {{16{shifted[15]}}, shifted[15:0]};
            end
            ld_hu: begin
                load_data = {16'b0, shifted[15:0]};
            end
            default: begin
                load_data = shifted; // ld_w, offset is zero when aligned
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/mul_finish.sv
`timescale 1ns/1ps
`default_nettype none

module mul_finish (
    input  wire  [63:0] mul_sum,
    input  wire  [63:0] mul_carry,
    input  wire         mul_high,
    output logic [31:0] mul_word
);

    logic [63:0] product;

    // final carry-propagate add of the tree output
    assign product = mul_sum + mul_carry;

    always_comb begin
        if (mul_high) begin
            mul_word = product[63:32];
        end else begin
            mul_word = product[31:0];
        end
    end

endmodule

`default_nettype wire

//--- source/wb_select.sv
`timescale 1ns/1ps
`default_nettype none

module wb_select (
    input  wire                         mem_valid,
    input  wire                         mem_flush,
    input  wire  mem_pkg::res_src_e     res_src,
    input  wire  [31:0]                 alu_result,
    input  wire  [31:0]                 div_result,
    input  wire  [31:0]                 load_data,
    input  wire  [31:0]                 mul_word,
    input  wire                         rf_we,
    input  wire  [4:0]                  rf_waddr,
    input  wire  [31:0]                 pc,
    input  wire                         has_ex,
    input  wire                         ertn,
    input  wire  [mem_pkg::ECODE_W-1:0] ecode,
    output wire                         wb_valid,
    output wire                         wb_rf_we,
    output wire  [4:0]                  wb_rf_waddr,
    output logic [31:0]                 wb_rf_wdata,
    output wire  [31:0]                 wb_pc,
    output wire                         wb_has_ex,
    output wire                         wb_ertn,
    output wire  [mem_pkg::ECODE_W-1:0] wb_ecode,
    output wire                         fwd_rf_we,
    output wire  [4:0]                  fwd_rf_waddr,
    output wire  [31:0]                 fwd_rf_wdata,
    output wire                         ms_to_es_ex
);

    import mem_pkg::*;

    always_comb begin
        case (res_src)
            src_mem:    wb_rf_wdata = load_data;
            src_mul_lo: wb_rf_wdata = mul_word;
            src_mul_hi: wb_rf_wdata = mul_word; // word already picked
            src_div:    wb_rf_wdata = div_result;
            default:    wb_rf_wdata = alu_result;
        endcase
    end

    assign wb_valid    = mem_valid & ~mem_flush;
    assign wb_rf_we    = rf_we;
    assign wb_rf_waddr = rf_waddr;
    assign wb_pc       = pc;
    assign wb_has_ex   = has_ex;
    assign wb_ertn     = ertn;
    assign wb_ecode    = ecode;

    // forwarding path back to decode
    assign fwd_rf_we    = rf_we & mem_valid;
    assign fwd_rf_waddr = rf_waddr;
    assign fwd_rf_wdata = wb_rf_wdata;

    assign ms_to_es_ex = (has_ex | ertn) & mem_valid; // blocks younger side effects

endmodule

`default_nettype wire

//--- source/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  wire                         clk,
    input  wire                         resetn,
    input  wire                         ex_valid,
    input  wire                         ex_rf_we,
    input  wire  [4:0]                  ex_rf_waddr,
    input  wire  [31:0]                 ex_pc,
    input  wire  [31:0]                 ex_alu_result,
    input  wire  [31:0]                 ex_div_result,
    input  wire  mem_pkg::ld_op_e       ex_ld_op,
    input  wire  mem_pkg::res_src_e     ex_res_src,
    input  wire                         ex_has_ex,
    input  wire                         ex_ertn,
    input  wire  [mem_pkg::ECODE_W-1:0] ex_ecode,
    output wire                         mem_allowin,
    input  wire  [31:0]                 data_sram_rdata,
    input  wire  [63:0]                 mul_sum,
    input  wire  [63:0]                 mul_carry,
    input  wire                         wb_allowin,
    input  wire                         mem_flush,
    output wire                         wb_valid,
    output wire                         wb_rf_we,
    output wire  [4:0]                  wb_rf_waddr,
    output wire  [31:0]                 wb_rf_wdata,
    output wire  [31:0]                 wb_pc,
    output wire                         wb_has_ex,
    output wire                         wb_ertn,
    output wire  [mem_pkg::ECODE_W-1:0] wb_ecode,
    output wire                         fwd_rf_we,
    output wire  [4:0]                  fwd_rf_waddr,
    output wire  [31:0]                 fwd_rf_wdata,
    output wire                         ms_to_es_ex
);

    import mem_pkg::*;

    logic                mem_valid;
    logic                ms_rf_we;
    logic [4:0]          ms_rf_waddr;
    logic [31:0]         ms_pc;
    logic [31:0]         ms_alu_result;
    logic [31:0]         ms_div_result;
    ld_op_e              ms_ld_op;
    res_src_e            ms_res_src;
    logic                ms_has_ex;
    logic                ms_ertn;
    logic [ECODE_W-1:0]  ms_ecode;
    logic [31:0]         load_data;
    logic [31:0]         mul_word;
    logic                mul_high;

    assign mul_high = (ms_res_src == src_mul_hi);

    mem_pipe_reg u_pipe_reg (
        .clk           (clk),
        .resetn        (resetn),
        .ex_valid      (ex_valid),
        .ex_rf_we      (ex_rf_we),
        .ex_rf_waddr   (ex_rf_waddr),
        .ex_pc         (ex_pc),
        .ex_alu_result (ex_alu_result),
        .ex_div_result (ex_div_result),
        .ex_ld_op      (ex_ld_op),
        .ex_res_src    (ex_res_src),
        .ex_has_ex     (ex_has_ex),
        .ex_ertn       (ex_ertn),
        .ex_ecode      (ex_ecode),
        .wb_allowin    (wb_allowin),
        .mem_flush     (mem_flush),
        .mem_allowin   (mem_allowin),
        .mem_valid     (mem_valid),
        .ms_rf_we      (ms_rf_we),
        .ms_rf_waddr   (ms_rf_waddr),
        .ms_pc         (ms_pc),
        .ms_alu_result (ms_alu_result),
        .ms_div_result (ms_div_result),
        .ms_ld_op      (ms_ld_op),
        .ms_res_src    (ms_res_src),
        .ms_has_ex     (ms_has_ex),
        .ms_ertn       (ms_ertn),
        .ms_ecode      (ms_ecode)
    );

    load_extract u_load_extract (
        .data_sram_rdata (data_sram_rdata),
        .byte_offset     (ms_alu_result[1:0]), // low address bits of the access
        .ld_op           (ms_ld_op),
        .load_data       (load_data)
    );

    mul_finish u_mul_finish (
        .mul_sum   (mul_sum),
        .mul_carry (mul_carry),
        .mul_high  (mul_high),
        .mul_word  (mul_word)
    );

    wb_select u_wb_select (
        .mem_valid    (mem_valid),
        .mem_flush    (mem_flush),
        .res_src      (ms_res_src),
        .alu_result   (ms_alu_result),
        .div_result   (ms_div_result),
        .load_data    (load_data),
        .mul_word     (mul_word),
        .rf_we        (ms_rf_we),
        .rf_waddr     (ms_rf_waddr),
        .pc           (ms_pc),
        .has_ex       (ms_has_ex),
        .ertn         (ms_ertn),
        .ecode        (ms_ecode),
        .wb_valid     (wb_valid),
        .wb_rf_we     (wb_rf_we),
        .wb_rf_waddr  (wb_rf_waddr),
        .wb_rf_wdata  (wb_rf_wdata),
        .wb_pc        (wb_pc),
        .wb_has_ex    (wb_has_ex),
        .wb_ertn      (wb_ertn),
        .wb_ecode     (wb_ecode),
        .fwd_rf_we    (fwd_rf_we),
        .fwd_rf_waddr (fwd_rf_waddr),
        .fwd_rf_wdata (fwd_rf_wdata),
        .ms_to_es_ex  (ms_to_es_ex)
    );

endmodule

`default_nettype wire

//--- sim/mem_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mem_checker (
    input wire clk, resetn, ex_valid, ex_rf_we, ex_has_ex, ex_ertn, wb_allowin, mem_flush,
    input wire [4:0] ex_rf_waddr,
    input wire [31:0] ex_pc, ex_alu_result, ex_div_result, data_sram_rdata,
    input wire [63:0] mul_sum, mul_carry,
    input wire [mem_pkg::ECODE_W-1:0] ex_ecode, wb_ecode,
    input wire mem_pkg::ld_op_e ex_ld_op,
    input wire mem_pkg::res_src_e ex_res_src,
    input wire mem_allowin, wb_valid, wb_rf_we, wb_has_ex, wb_ertn, fwd_rf_we, ms_to_es_ex,
    input wire [4:0] wb_rf_waddr, fwd_rf_waddr,
    input wire [31:0] wb_rf_wdata, wb_pc, fwd_rf_wdata,
    input string test_name
);

    import mem_pkg::*;

    int value_errors = 0;
    int protocol_errors = 0;
    int transfers = 0;
    int held_cycles = 0;
    bit held = 0;
    logic h_we, h_has_ex, h_ertn;
    logic [4:0] h_waddr;
    logic [31:0] h_pc, h_alu, h_div;
    logic [ECODE_W-1:0] h_ecode;
    ld_op_e h_ld;
    res_src_e h_src;

    function automatic logic [31:0] expect_data();
        logic [31:0] sh;
        logic [63:0] prod;
        sh = data_sram_rdata >> (8 * h_alu[1:0]);
        prod = mul_sum + mul_carry;
        case (h_src)
            src_mul_lo: return prod[31:0];
            src_mul_hi: return prod[63:32];
            src_div:    return h_div;
            src_alu:    return h_alu;
            default: begin
                case (h_ld)
                    ld_b:    return {{24{sh[7]}}, sh[7:0]};
                    ld_bu:   return {24'h0, sh[7:0]};
                    ld_h:    return {{16{sh[15]}}, sh[15:0]};
                    ld_hu:   return {16'h0, sh[15:0]};
                    default: return sh;
                endcase
            end
        endcase
    endfunction

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
            value_errors++;
        end
    endtask

    always @(posedge clk) begin
        if (!resetn) begin
            held = 0;
        end else begin
            compare("wb_valid", held && !mem_flush, wb_valid);
            compare("mem_allowin", !held || wb_allowin || mem_flush, mem_allowin);
            compare("fwd_rf_we", held & h_we, fwd_rf_we);
            compare("ms_to_es_ex", held & (h_has_ex | h_ertn), ms_to_es_ex);
            if (held && !mem_flush) begin
                compare("wb_rf_wdata", expect_data(), wb_rf_wdata);
                compare("fwd_rf_wdata", expect_data(), fwd_rf_wdata);
                compare("wb_rf_waddr", h_waddr, wb_rf_waddr);
                compare("fwd_rf_waddr", h_waddr, fwd_rf_waddr);
                compare("wb_rf_we", h_we, wb_rf_we);
                compare("wb_pc", h_pc, wb_pc);
                compare("wb_has_ex", h_has_ex, wb_has_ex);
                compare("wb_ertn", h_ertn, wb_ertn);
                compare("wb_ecode", h_ecode, wb_ecode);
            end
            if (held && (mem_flush || wb_allowin)) begin
                if (!mem_flush) transfers++; // taken by writeback
                held = 0;
            end else if (held) begin
                held_cycles++;
                if (held_cycles > 40) begin
                    $display("item in %s never reached writeback", test_name);
                    protocol_errors++;
                    held = 0;
                end
            end
            if (ex_valid && mem_allowin) begin
                held = 1;
                held_cycles = 0;
                h_we = ex_rf_we;
                h_waddr = ex_rf_waddr;
                h_pc = ex_pc;
                h_alu = ex_alu_result;
                h_div = ex_div_result;
                h_ld = ex_ld_op;
                h_src = ex_res_src;
                h_has_ex = ex_has_ex;
                h_ertn = ex_ertn;
                h_ecode = ex_ecode;
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_stage;

    import mem_pkg::*;

    typedef struct {
        string         name;
        ld_op_e        ld_op;
        res_src_e      res_src;
        logic [4:0]    waddr;
        logic          we;
        logic [31:0]   pc;
        logic [31:0]   alu;
        logic [31:0]   div;
        logic [31:0]   rdata;
        logic [63:0]   sum;
        logic [63:0]   carry;
        logic          has_ex;
        logic          ertn;
        logic [ECODE_W-1:0] ecode;
        logic          flush;
        int            stall;
    } entry_t;

    logic clk = 1'b0;
    logic resetn, ex_valid, ex_rf_we, ex_has_ex, ex_ertn, wb_allowin, mem_flush;
    logic [4:0] ex_rf_waddr;
    logic [31:0] ex_pc, ex_alu_result, ex_div_result, data_sram_rdata;
    logic [63:0] mul_sum, mul_carry;
    logic [ECODE_W-1:0] ex_ecode;
    ld_op_e ex_ld_op;
    res_src_e ex_res_src;
    wire mem_allowin, wb_valid, wb_rf_we, wb_has_ex, wb_ertn, fwd_rf_we, ms_to_es_ex;
    wire [4:0] wb_rf_waddr, fwd_rf_waddr;
    wire [31:0] wb_rf_wdata, wb_pc, fwd_rf_wdata;
    wire [ECODE_W-1:0] wb_ecode;
    string cur_name = "idle";
    entry_t table_q[$];
    int wait_errors = 0;
    int expected_transfers = 0;

    always #10 clk = ~clk;

    mem_stage u_dut (.*);

    mem_checker u_chk (.*, .test_name(cur_name));

    task automatic add_entry(input string name, input ld_op_e ld, input res_src_e src,
                             input logic [31:0] alu, input logic [31:0] rdata,
                             input logic [63:0] sum, input logic [63:0] carry,
                             input logic has_ex, input logic ertn, input logic flush,
                             input int stall);
        entry_t e;
        e.name = name;
        e.ld_op = ld;
        e.res_src = src;
        e.waddr = 5'(table_q.size() + 1);
        e.we = (table_q.size() % 5) != 3;
        e.pc = 32'h1c00_0000 + 32'(table_q.size() * 4);
        e.alu = alu;
        e.div = 32'hd1d0_0000 ^ alu;
        e.rdata = rdata;
        e.sum = sum;
        e.carry = carry;
        e.has_ex = has_ex;
        e.ertn = ertn;
        e.ecode = has_ex ? 6'h0b : 6'h00;
        e.flush = flush;
        e.stall = stall;
        table_q.push_back(e);
    endtask

    task automatic build_table();
        ld_op_e kinds[4] = '{ld_b, ld_bu, ld_h, ld_hu};
        for (int k = 0; k < 4; k++) begin
            for (int off = 0; off < 4; off++) begin
                add_entry($sformatf("load_%s_off%0d", kinds[k].name(), off), kinds[k], src_mem,
                          32'h0000_1000 + off, 32'h80f1_7f8e, 0, 0, 0, 0, 0, k % 2);
                add_entry($sformatf("load2_%s_off%0d", kinds[k].name(), off), kinds[k], src_mem,
                          32'h0000_2000 + off, 32'h7f00_80ff, 0, 0, 0, 0, 0, 0);
            end
        end
        add_entry("load_w", ld_w, src_mem, 32'h0000_3000, 32'hdead_beef, 0, 0, 0, 0, 0, 1);
        add_entry("mul_lo_carry", ld_none, src_mul_lo, 32'h5, 0,
                  64'h0000_0000_8000_0000, 64'h0000_0002_8000_0001, 0, 0, 0, 0);
        add_entry("mul_hi_carry", ld_none, src_mul_hi, 32'h6, 0,
                  64'h0000_0000_8000_0000, 64'h0000_0002_8000_0001, 0, 0, 0, 2);
        add_entry("mul_hi_wrap", ld_none, src_mul_hi, 32'h7, 0,
                  64'hffff_fffe_ffff_ffff, 64'h1, 0, 0, 0, 0);
        add_entry("mul_lo_big", ld_none, src_mul_lo, 32'h8, 0,
                  64'h1234_5678_9abc_def0, 64'h0fed_cba9_8765_4321, 0, 0, 0, 3);
        add_entry("alu_pass", ld_none, src_alu, 32'hcafe_f00d, 0, 0, 0, 0, 0, 0, 0);
        add_entry("div_pass", ld_none, src_div, 32'h0bad_cafe, 0, 0, 0, 0, 0, 0, 2);
        add_entry("exc_has_ex", ld_none, src_alu, 32'h1111_2222, 0, 0, 0, 1, 0, 0, 1);
        add_entry("exc_ertn", ld_none, src_alu, 32'h3333_4444, 0, 0, 0, 0, 1, 0, 0);
        add_entry("flush_held", ld_w, src_mem, 32'h0000_4000, 32'h5555_aaaa, 0, 0, 0, 0, 1, 0);
        add_entry("flush_stalled", ld_none, src_div, 32'h9, 0, 0, 0, 1, 0, 1, 3);
        add_entry("after_flush", ld_none, src_alu, 32'h7777_8888, 0, 0, 0, 0, 0, 0, 1);
    endtask

    task automatic wait_allowin();
        int n = 0;
        while (!mem_allowin && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (!mem_allowin) begin
            $display("timeout waiting for mem_allowin in %s", cur_name);
            wait_errors++;
        end
    endtask

    task automatic wait_transfer();
        int n = 0;
        bit done = 0;
        while (!done && n < 50) begin
            @(posedge clk);
            done = wb_valid && wb_allowin;
            n++;
        end
        if (!done) begin
            $display("timeout waiting for writeback transfer in %s", cur_name);
            wait_errors++;
        end
    endtask

    task automatic apply_entry(input entry_t e);
        int extra;
        @(negedge clk);
        cur_name = e.name;
        ex_valid = 1'b1;
        ex_ld_op = e.ld_op;
        ex_res_src = e.res_src;
        ex_rf_waddr = e.waddr;
        ex_rf_we = e.we;
        ex_pc = e.pc;
        ex_alu_result = e.alu;
        ex_div_result = e.div;
        ex_has_ex = e.has_ex;
        ex_ertn = e.ertn;
        ex_ecode = e.ecode;
        data_sram_rdata = e.rdata;
        mul_sum = e.sum;
        mul_carry = e.carry;
        wait_allowin();
        @(posedge clk);
        @(negedge clk);
        ex_valid = 1'b0;
        extra = $urandom_range(0, 2);
        for (int i = 0; i < e.stall + extra; i++) begin
            wb_allowin = 1'b0;
            @(negedge clk);
        end
        if (e.flush) begin
            mem_flush = 1'b1;
            @(negedge clk);
            mem_flush = 1'b0;
            wb_allowin = 1'b1;
        end else begin
            wb_allowin = 1'b1;
            expected_transfers++;
            wait_transfer();
        end
    endtask

    initial begin
        void'($urandom(1058));
        resetn = 1'b0;
        ex_valid = 1'b0;
        ex_rf_we = 1'b0;
        ex_has_ex = 1'b0;
        ex_ertn = 1'b0;
        wb_allowin = 1'b1;
        mem_flush = 1'b0;
        ex_rf_waddr = '0;
        ex_pc = '0;
        ex_alu_result = '0;
        ex_div_result = '0;
        data_sram_rdata = '0;
        mul_sum = '0;
        mul_carry = '0;
        ex_ecode = '0;
        ex_ld_op = ld_none;
        ex_res_src = src_alu;
        build_table();
        repeat (4) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        repeat (2) @(negedge clk);
        foreach (table_q[i]) apply_entry(table_q[i]);
        repeat (3) @(negedge clk);
        if (u_chk.transfers != expected_transfers) begin
            $display("transfer count wrong, expected %0d, saw %0d",
                     expected_transfers, u_chk.transfers);
            wait_errors++;
        end
        $display("errors: value=%0d protocol=%0d wait=%0d", u_chk.value_errors,
                 u_chk.protocol_errors, wait_errors);
        if (u_chk.value_errors + u_chk.protocol_errors + wait_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- mem_stage.f
source/mem_pkg.sv
source/mem_pipe_reg.sv
source/load_extract.sv
source/mul_finish.sv
source/wb_select.sv
source/mem_stage.sv
sim/mem_checker.sv
sim/tb_mem_stage.sv
